//--- ili9341Ctrl.f
lcdBusPkg.sv
lcdPixelPkg.sv
pixelInput.sv
cmdRom.sv
lcdSequencer.sv
bus8080Writer.sv
ili9341Ctrl.sv
tbIli9341Ctrl.sv

//--- Makefile
# Verilator lint and simulation of the ILI9341 controller testbench

VERILATOR  = verilator
TOP        = tbIli9341Ctrl
FILELIST   = ili9341Ctrl.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
FAIL_MSG   = Checks failed
PASS_MSG   = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides the result, a run that stops early has no pass line either
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tbIli9341Ctrl.sv
// Testbench for the ILI9341 controller; random pixel stream checked against a model of the panel bus
module tbIli9341Ctrl;
    import lcdBusPkg::*;
    import lcdPixelPkg::*;

    // Small frame and short delays for simulation
    localparam int frameWidth   = 4;
    localparam int frameHeight  = 3;
    localparam int holdCycles   = 20;
    localparam int waitCycles   = 15;
    localparam int sleepCycles  = 30;
    localparam int frames       = 3;
    localparam int startBytes   = 6;
    localparam int windowBytes  = 11;
    // Window list then two bytes per pixel
    localparam int frameBytes   = windowBytes + 2 * frameWidth * frameHeight;
    localparam int totalBytes   = startBytes + frames * frameBytes;
    // Reset and start-up allowance plus worst case per frame byte
    localparam int cycleLimit   = 40 + 30 + frames * (13 + 24) * 2 * 4;

    logic     clk;
    logic     reset;
    pixel_t   pixelIn;
    logic     pixelValid;
    logic     pixelReady;
    tftPins_t tftPins;

    // Accepted pixels not yet seen on the bus
    logic [15:0] pixelQueue[$];
    logic [15:0] currentPixel;
    logic [7:0]  prevData;
    logic        prevWrLow;
    logic        resetRose;
    logic        holdPixel;
    logic        finished;
    int          valueErrors;
    int          otherErrors;
    int          byteCount;
    int          cycleCount;
    int          resetLowCycles;
    int          riseCycle;
    int          sleepOutCycle;

    ili9341Ctrl
    #(
        .frameWidth         (frameWidth),
        .frameHeight        (frameHeight),
        .resetHoldCycles    (holdCycles),
        .resetWaitCycles    (waitCycles),
        .sleepOutWaitCycles (sleepCycles)
    )
    ili9341Ctrl_i
    (
        .clk        (clk),
        .reset      (reset),
        .pixelIn    (pixelIn),
        .pixelValid (pixelValid),
        .pixelReady (pixelReady),
        .tftPins    (tftPins)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Start-up list at 0..5 and window list from 6 with the data flag in bit 8
    function automatic logic [8:0] listByte(input int index);
        logic [15:0] columnEnd;
        logic [15:0] pageEnd;
        columnEnd = 16'(frameWidth - 1);
        pageEnd   = 16'(frameHeight - 1);
        case (index)
            0: return {1'b0, 8'h3A};
            1: return {1'b1, 8'h55};
            2: return {1'b0, 8'h36};
            3: return {1'b1, 8'h48};
            4: return {1'b0, 8'h11};
            5: return {1'b0, 8'h29};
            6: return {1'b0, 8'h2A};
            7, 8: return {1'b1, 8'h00};
            9: return {1'b1, columnEnd[15:8]};
            10: return {1'b1, columnEnd[7:0]};
            11: return {1'b0, 8'h2B};
            12, 13: return {1'b1, 8'h00};
            14: return {1'b1, pageEnd[15:8]};
            15: return {1'b1, pageEnd[7:0]};
            16: return {1'b0, 8'h2C};
            default: return 9'h000;
        endcase
    endfunction

    // Compare one strobed byte with the next byte of the model stream
    task automatic checkByte(input logic [8:0] actual);
        int         offset;
        int         pixelByte;
        logic [8:0] expected;
        string      testName;
        if (byteCount < startBytes)
        begin
            testName = "startup";
            expected = listByte(byteCount);
        end
        else
        begin
            offset = (byteCount - startBytes) % frameBytes;
            if (offset < windowBytes)
            begin
                testName = "window";
                expected = listByte(startBytes + offset);
            end
            else
            begin
                testName  = "pixel";
                pixelByte = offset - windowBytes;
                // High byte opens the next queued pixel
                if (pixelByte % 2 == 0)
                begin
                    assert (pixelQueue.size() > 0)
                    else
                    begin
                        $display("Pixel byte %0d on the bus with no accepted pixel", byteCount);
                        otherErrors++;
                    end
                    if (pixelQueue.size() > 0)
                        currentPixel = pixelQueue.pop_front();
                end
                if (pixelByte % 2 == 0)
                    expected = {1'b1, currentPixel[15:8]};
                else
                    expected = {1'b1, currentPixel[7:0]};
            end
        end
        assert (actual == expected)
        else
        begin
            $display("[ERROR] %s byte %0d: expected %h, actual %h",
                     testName, byteCount, expected, actual);
            valueErrors++;
        end
        // Sleep-out to display-on spacing
        if (byteCount == 4)
            sleepOutCycle = cycleCount;
        if (byteCount == 5)
        begin
            assert (cycleCount - sleepOutCycle >= sleepCycles)
            else
            begin
                $display("Display-on came only %0d cycles after sleep-out",
                         cycleCount - sleepOutCycle);
                otherErrors++;
            end
        end
        byteCount++;
    endtask

    // Sampled on the falling edge where all pins are settled
    task automatic monitorPins();
        if (!resetRose)
        begin
            if (!tftPins.resetN)
                resetLowCycles++;
            else
            begin
                resetRose = 1'b1;
                riseCycle = cycleCount;
                assert (resetLowCycles == holdCycles)
                else
                begin
                    $display("[ERROR] panel reset: expected %0d, actual %0d",
                             holdCycles, resetLowCycles);
                    valueErrors++;
                end
            end
        end
        else
        begin
            assert (tftPins.resetN)
            else
            begin
                $display("Panel reset went low again after release");
                otherErrors++;
            end
        end
        // Port holds the byte in the cycle after a strobe
        if (prevWrLow)
        begin
            assert (tftPins.wrN)
            else
            begin
                $display("Write strobe stayed low for more than one cycle");
                otherErrors++;
            end
            assert (tftPins.data == prevData)
            else
            begin
                $display("[ERROR] strobe hold: expected %h, actual %h", prevData, tftPins.data);
                valueErrors++;
            end
        end
        if (!tftPins.wrN)
        begin
            assert (!tftPins.csN)
            else
            begin
                $display("Chip select high during a write strobe");
                otherErrors++;
            end
            assert (resetRose && tftPins.resetN)
            else
            begin
                $display("Write strobe while the panel is held in reset");
                otherErrors++;
            end
            if (byteCount == 0)
            begin
                assert (cycleCount - riseCycle > waitCycles)
                else
                begin
                    $display("First write strobe only %0d cycles after panel reset release",
                             cycleCount - riseCycle);
                    otherErrors++;
                end
            end
            if (byteCount < totalBytes)
                checkByte({tftPins.cmdN, tftPins.data});
        end
        prevWrLow = !tftPins.wrN;
        prevData  = tftPins.data;
        // Stop once the last byte has also passed its hold cycle
        finished  = (byteCount == totalBytes) && tftPins.wrN;
    endtask

    // Random valid with the pixel held while offered and not taken
    task automatic drivePixel();
        if (!holdPixel)
        begin
            pixelValid = ($urandom_range(99) < 70);
            pixelIn    = 16'($urandom());
        end
        // Ready only moves on the rising edge, so this decides the coming transfer
        if (pixelValid && pixelReady)
            pixelQueue.push_back(pixelIn);
        holdPixel = pixelValid && !pixelReady;
    endtask

    initial
    begin
        void'($urandom(32'h3168));
        reset          = 1'b1;
        pixelIn        = '0;
        pixelValid     = 1'b0;
        currentPixel   = '0;
        prevData       = '0;
        prevWrLow      = 1'b0;
        resetRose      = 1'b0;
        holdPixel      = 1'b0;
        finished       = 1'b0;
        valueErrors    = 0;
        otherErrors    = 0;
        byteCount      = 0;
        cycleCount     = 0;
        resetLowCycles = 0;
        riseCycle      = 0;
        sleepOutCycle  = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!finished && cycleCount < cycleLimit)
        begin
            monitorPins();
            drivePixel();
            @(negedge clk);
            cycleCount++;
        end
        if (!finished)
        begin
            $display("Timeout after %0d cycles with %0d of %0d bytes seen",
                     cycleCount, byteCount, totalBytes);
            otherErrors++;
        end
        $display("Error counts: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- ili9341Ctrl.sv
// Top level of the ILI9341 8080 bus controller; sets timing and frame size and links the stages
module ili9341Ctrl
#(
    parameter int frameWidth         = lcdPixelPkg::defaultFrameWidth,
    parameter int frameHeight        = lcdPixelPkg::defaultFrameHeight,
    parameter int resetHoldCycles    = 1000,
    parameter int resetWaitCycles    = 6000,
    parameter int sleepOutWaitCycles = 6000
)
(
    input  logic                clk,
    input  logic                reset,
    input  lcdPixelPkg::pixel_t pixelIn,
    input  logic                pixelValid,
    output logic                pixelReady,
    output lcdBusPkg::tftPins_t tftPins
);
    import lcdBusPkg::*;

    // Pixel bytes into the sequencer
    busWord_t   pixWord;
    logic       pixWordValid;
    logic       pixWordReady;
    // Sequencer to bus writer
    busWord_t   outWord;
    logic       outValid;
    logic       outReady;
    // Table lookup
    logic [4:0] romIndex;
    romEntry_t  romEntry;
    logic       panelResetN;

    pixelInput pixelInput_i
    (
        .clk          (clk),
        .reset        (reset),
        .pixelIn      (pixelIn),
        .pixelValid   (pixelValid),
        .pixelReady   (pixelReady),
        .pixWord      (pixWord),
        .pixWordValid (pixWordValid),
        .pixWordReady (pixWordReady)
    );

    cmdRom #(.frameWidth(frameWidth), .frameHeight(frameHeight)) cmdRom_i
    (
        .romIndex (romIndex),
        .romEntry (romEntry)
    );

    lcdSequencer
    #(
        .resetHoldCycles    (resetHoldCycles),
        .resetWaitCycles    (resetWaitCycles),
        .sleepOutWaitCycles (sleepOutWaitCycles),
        .frameWidth         (frameWidth),
        .frameHeight        (frameHeight)
    )
    lcdSequencer_i
    (
        .clk          (clk),
        .reset        (reset),
        .romIndex     (romIndex),
        .romEntry     (romEntry),
        .pixWord      (pixWord),
        .pixWordValid (pixWordValid),
        .pixWordReady (pixWordReady),
        .outWord      (outWord),
        .outValid     (outValid),
        .outReady     (outReady),
        .panelResetN  (panelResetN)
    );

    bus8080Writer bus8080Writer_i
    (
        .clk         (clk),
        .reset       (reset),
        .outWord     (outWord),
        .outValid    (outValid),
        .outReady    (outReady),
        .panelResetN (panelResetN),
        .tftPins     (tftPins)
    );

endmodule

//--- bus8080Writer.sv
// Output stage; drives one two-cycle 8080 write strobe per accepted bus word onto the panel pins
module bus8080Writer
(
    input  logic                clk,
    input  logic                reset,
    input  lcdBusPkg::busWord_t outWord,
    input  logic                outValid,
    output logic                outReady,
    input  logic                panelResetN,
    output lcdBusPkg::tftPins_t tftPins
);
    import lcdBusPkg::*;

    // Byte on the bus and its data flag
    busWord_t busWord;
    // Strobe phase, high while the write strobe is low
    logic     strobeLow;
    // A byte occupies the bus this cycle
    logic     active;

    // New word only once the strobe is back high
    assign outReady = !strobeLow;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busWord   <= '0;
            strobeLow <= 1'b0;
            active    <= 1'b0;
        end
        else if (outValid && outReady)
        begin
            busWord   <= outWord;
            strobeLow <= 1'b1;
            active    <= 1'b1;
        end
        else if (strobeLow)
            // Rising strobe, byte stays on the port
            strobeLow <= 1'b0;
        else
            active <= 1'b0;
    end

    // Pin mapping
    assign tftPins.data   = busWord.value;
    assign tftPins.csN    = !active;
    assign tftPins.wrN    = !strobeLow;
    assign tftPins.cmdN   = busWord.isData;
    assign tftPins.resetN = panelResetN;

    // Panel latches on the rising edge, so every low pulse is one cycle
    assert property (@(posedge clk) disable iff (reset) !tftPins.wrN |=> tftPins.wrN);

endmodule

//--- lcdSequencer.sv
// Controller FSM for panel reset timing, start-up list, sleep-out delay, window list and pixel bytes
module lcdSequencer
#(
    parameter int resetHoldCycles    = 10,
    parameter int resetWaitCycles    = 10,
    parameter int sleepOutWaitCycles = 10,
    parameter int frameWidth         = 240,
    parameter int frameHeight        = 320
)
(
    input  logic                 clk,
    input  logic                 reset,
    output logic [4:0]           romIndex,
    input  lcdBusPkg::romEntry_t romEntry,
    input  lcdBusPkg::busWord_t  pixWord,
    input  logic                 pixWordValid,
    output logic                 pixWordReady,
    output lcdBusPkg::busWord_t  outWord,
    output logic                 outValid,
    input  logic                 outReady,
    output logic                 panelResetN
);
    import lcdBusPkg::*;

    // Delay counter sized for the longest wait
    localparam int holdOrWait = (resetHoldCycles > resetWaitCycles) ?
                                resetHoldCycles : resetWaitCycles;
    localparam int maxDelay   = (holdOrWait > sleepOutWaitCycles) ?
                                holdOrWait : sleepOutWaitCycles;
    localparam int delayWidth = $clog2(maxDelay + 1);

    // Two bus bytes per pixel
    localparam int frameBytes = 2 * frameWidth * frameHeight;
    localparam int countWidth = $clog2(frameBytes);

    typedef enum logic [2:0]
    {
        resetHold,
        resetWait,
        startList,
        sleepWait,
        windowList,
        pixels
    } seqState_t;

    seqState_t             state;
    logic [delayWidth-1:0] delayCount;
    logic [countWidth-1:0] pixelCount;
    logic                  delayDone;
    logic                  listState;
    logic                  wordTaken;

    assign delayDone = (delayCount == '0);
    assign listState = (state == startList) || (state == windowList);

    // Table words in the list states, pixel bytes pass straight through otherwise
    assign outWord      = (state == pixels) ? pixWord : romEntry.word;
    assign outValid     = listState || ((state == pixels) && pixWordValid);
    assign pixWordReady = (state == pixels) && outReady;
    assign wordTaken    = outValid && outReady;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= resetHold;
            delayCount  <= delayWidth'(resetHoldCycles - 1);
            panelResetN <= 1'b0;
            romIndex    <= 5'd0;
            pixelCount  <= '0;
        end
        else
        begin
            case (state)
                resetHold:
                begin
                    // Release the panel once the hold time is up
                    if (delayDone)
                    begin
                        state       <= resetWait;
                        panelResetN <= 1'b1;
                        delayCount  <= delayWidth'(resetWaitCycles - 1);
                    end
                    else
                        delayCount <= delayCount - 1'b1;
                end
                resetWait:
                begin
                    if (delayDone)
                    begin
                        state    <= startList;
                        romIndex <= 5'd0;
                    end
                    else
                        delayCount <= delayCount - 1'b1;
                end
                startList:
                begin
                    if (wordTaken)
                    begin
                        if (romEntry.waitAfter)
                        begin
                            // Sleep-out needs a pause before the next command
                            state      <= sleepWait;
                            romIndex   <= romIndex + 5'd1;
                            delayCount <= delayWidth'(sleepOutWaitCycles - 1);
                        end
                        else if (romEntry.last)
                        begin
                            state    <= windowList;
                            romIndex <= windowStart;
                        end
                        else
                            romIndex <= romIndex + 5'd1;
                    end
                end
                sleepWait:
                begin
                    // Resume the start-up list at the entry after sleep-out
                    if (delayDone)
                        state <= startList;
                    else
                        delayCount <= delayCount - 1'b1;
                end
                windowList:
                begin
                    if (wordTaken)
                    begin
                        if (romEntry.last)
                        begin
                            state      <= pixels;
                            pixelCount <= '0;
                        end
                        else
                            romIndex <= romIndex + 5'd1;
                    end
                end
                pixels:
                begin
                    if (wordTaken)
                    begin
                        // Frame done, next one starts with the window again
                        if (pixelCount == countWidth'(frameBytes - 1))
                        begin
                            state    <= windowList;
                            romIndex <= windowStart;
                        end
                        else
                            pixelCount <= pixelCount + 1'b1;
                    end
                end
                default:
                    state <= resetHold;
            endcase
        end
    end

    // No byte may reach the bus while the panel sits in reset
    assert property (@(posedge clk) disable iff (reset) !(outValid && !panelResetN));

endmodule

//--- cmdRom.sv
// Command table holding the start-up list and the per-frame window list for the sequencer
module cmdRom
#(
    parameter int frameWidth  = 240,
    parameter int frameHeight = 320
)
(
    input  logic [4:0]           romIndex,
    output lcdBusPkg::romEntry_t romEntry
);
    import lcdBusPkg::*;

    // Last column and last page of the window
    localparam logic [15:0] columnEnd = 16'(frameWidth - 1);
    localparam logic [15:0] pageEnd   = 16'(frameHeight - 1);

    function automatic romEntry_t makeEntry
    (
        input logic       isData,
        input logic [7:0] value,
        input logic       waitAfter,
        input logic       last
    );
        romEntry_t entry;
        entry.waitAfter   = waitAfter;
        entry.last        = last;
        entry.word.isData = isData;
        entry.word.value  = value;
        return entry;
    endfunction

    always_comb
    begin
        case (romIndex)
            // Start-up list
            5'd0: romEntry = makeEntry(1'b0, cmdPixelFormat, 1'b0, 1'b0);
            5'd1: romEntry = makeEntry(1'b1, pixelFormat16Bit, 1'b0, 1'b0);
            5'd2: romEntry = makeEntry(1'b0, cmdAccessControl, 1'b0, 1'b0);
            5'd3: romEntry = makeEntry(1'b1, accessControlValue, 1'b0, 1'b0);
            // Panel needs time to wake before display-on
            5'd4: romEntry = makeEntry(1'b0, cmdSleepOut, 1'b1, 1'b0);
            5'd5: romEntry = makeEntry(1'b0, cmdDisplayOn, 1'b0, 1'b1);
            // Window list, column range from zero
            windowStart + 5'd0: romEntry = makeEntry(1'b0, cmdColumnSet, 1'b0, 1'b0);
            windowStart + 5'd1: romEntry = makeEntry(1'b1, 8'h00, 1'b0, 1'b0);
            windowStart + 5'd2: romEntry = makeEntry(1'b1, 8'h00, 1'b0, 1'b0);
            windowStart + 5'd3: romEntry = makeEntry(1'b1, columnEnd[15:8], 1'b0, 1'b0);
            windowStart + 5'd4: romEntry = makeEntry(1'b1, columnEnd[7:0], 1'b0, 1'b0);
            // Page range from zero
            windowStart + 5'd5: romEntry = makeEntry(1'b0, cmdPageSet, 1'b0, 1'b0);
            windowStart + 5'd6: romEntry = makeEntry(1'b1, 8'h00, 1'b0, 1'b0);
            windowStart + 5'd7: romEntry = makeEntry(1'b1, 8'h00, 1'b0, 1'b0);
            windowStart + 5'd8: romEntry = makeEntry(1'b1, pageEnd[15:8], 1'b0, 1'b0);
            windowStart + 5'd9: romEntry = makeEntry(1'b1, pageEnd[7:0], 1'b0, 1'b0);
            // Pixel bytes follow the memory write
            windowStart + 5'd10: romEntry = makeEntry(1'b0, cmdMemoryWrite, 1'b0, 1'b1);
            // Unused slots end any list
            default: romEntry = makeEntry(1'b0, 8'h00, 1'b0, 1'b1);
        endcase
    end

endmodule

//--- pixelInput.sv
// Pixel input stage; buffers one RGB565 pixel from the stream and offers it as two data bytes
module pixelInput
(
    input  logic                clk,
    input  logic                reset,
    input  lcdPixelPkg::pixel_t pixelIn,
    input  logic                pixelValid,
    output logic                pixelReady,
    output lcdBusPkg::busWord_t pixWord,
    output logic                pixWordValid,
    input  logic                pixWordReady
);
    import lcdBusPkg::*;

    // Buffered pixel qualified by full
    logic [15:0] pixBuf;
    logic        full;
    // Low byte goes next
    logic        lowNext;
    logic        wordTaken;
    logic        pixelTaken;

    assign wordTaken  = pixWordValid && pixWordReady;
    // Room when empty or when the last byte leaves this cycle
    assign pixelReady = !full || (wordTaken && lowNext);
    assign pixelTaken = pixelValid && pixelReady;

    assign pixWordValid  = full;
    assign pixWord.isData = 1'b1;
    // High byte first
    assign pixWord.value  = lowNext ? pixBuf[7:0] : pixBuf[15:8];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            full    <= 1'b0;
            lowNext <= 1'b0;
        end
        else
        begin
            if (wordTaken)
            begin
                // Buffer frees after the low byte
                if (lowNext)
                    full <= 1'b0;
                lowNext <= !lowNext;
            end
            // A new pixel overrides the freeing above
            if (pixelTaken)
            begin
                full    <= 1'b1;
                lowNext <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pixelTaken)
            pixBuf <= pixelIn;
    end

    // Offered byte holds until the sequencer takes it
    assert property (@(posedge clk) disable iff (reset)
        pixWordValid && !pixWordReady |=> pixWordValid && $stable(pixWord));

endmodule

//--- lcdPixelPkg.sv
// Pixel format definitions for the stream input and the top-level frame size defaults
package lcdPixelPkg;

    // RGB565, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // Native panel size in portrait orientation
    localparam int defaultFrameWidth  = 240;
    localparam int defaultFrameHeight = 320;

endpackage

//--- lcdBusPkg.sv
// Panel bus and command protocol definitions shared by the sequencer, command table and bus writer
package lcdBusPkg;

    // One byte for the panel, tagged as data or command
    typedef struct packed {
        logic       isData;
        logic [7:0] value;
    } busWord_t;

    // Panel pins, controls are active low
    typedef struct packed {
        logic [7:0] data;
        logic       csN;
        logic       wrN;
        // Low for a command byte, high for a data byte
        logic       cmdN;
        logic       resetN;
    } tftPins_t;

    // Command table entry
    typedef struct packed {
        // Hold off for the sleep-out time once this word has gone
        logic     waitAfter;
        // Final entry of a list
        logic     last;
        busWord_t word;
    } romEntry_t;

    // ILI9341 command codes
    localparam logic [7:0] cmdSleepOut      = 8'h11;
    localparam logic [7:0] cmdDisplayOn     = 8'h29;
    localparam logic [7:0] cmdColumnSet     = 8'h2A;
    localparam logic [7:0] cmdPageSet       = 8'h2B;
    localparam logic [7:0] cmdMemoryWrite   = 8'h2C;
    localparam logic [7:0] cmdPixelFormat   = 8'h3A;
    localparam logic [7:0] cmdAccessControl = 8'h36;

    // Parameter bytes for the start-up list
    localparam logic [7:0] pixelFormat16Bit   = 8'h55;
    localparam logic [7:0] accessControlValue = 8'h48;

    // First table index of the per-frame window list
    localparam logic [4:0] windowStart = 5'd6;

endpackage
